//--- rtl/swu_defs.svh
`ifndef SWU_DEFS_SVH
`define SWU_DEFS_SVH

////////////////////////////////////////////////////////////
// feature map geometry
////////////////////////////////////////////////////////////

`define SWU_IFM_W 9
`define SWU_IFM_H 9

// channel groups per pixel, channels per word
`define SWU_CH 2
`define SWU_SIMD 2
`define SWU_PREC 8

////////////////////////////////////////////////////////////
// window geometry
////////////////////////////////////////////////////////////

`define SWU_KERNEL 3
`define SWU_STRIDE 2

`define SWU_OFM_W (((`SWU_IFM_W - `SWU_KERNEL) / `SWU_STRIDE) + 1)
`define SWU_OFM_H (((`SWU_IFM_H - `SWU_KERNEL) / `SWU_STRIDE) + 1)

// kernel rows plus one stride of rows being refilled
`define SWU_BUF_ROWS (`SWU_KERNEL + `SWU_STRIDE)
`define SWU_BUF_DEPTH (`SWU_BUF_ROWS * `SWU_IFM_W * `SWU_CH)

`endif

//--- rtl/stream_pkg.sv
`include "swu_defs.svh"

package stream_pkg;

   ////////////////////////////////////////////////////////////
   // stream payloads
   ////////////////////////////////////////////////////////////

   localparam int PIXEL_W = `SWU_SIMD * `SWU_PREC;

   // one channel group of one pixel
   typedef logic [PIXEL_W-1:0] pixel_t;

   // output word with its window and frame markers
   typedef struct packed {
      pixel_t data;
      logic   win_last;
      logic   frame_last;
   } out_beat_t;

endpackage

//--- rtl/window_pkg.sv
`include "swu_defs.svh"

package window_pkg;

   ////////////////////////////////////////////////////////////
   // counter widths
   ////////////////////////////////////////////////////////////

   localparam int OROW_W = (`SWU_OFM_H > 1) ? $clog2(`SWU_OFM_H) : 1;
   localparam int OCOL_W = (`SWU_OFM_W > 1) ? $clog2(`SWU_OFM_W) : 1;
   localparam int K_W    = (`SWU_KERNEL > 1) ? $clog2(`SWU_KERNEL) : 1;
   localparam int CH_W   = (`SWU_CH > 1) ? $clog2(`SWU_CH) : 1;
   localparam int ADDR_W = $clog2(`SWU_BUF_DEPTH);
   localparam int ROW_W  = $clog2(`SWU_IFM_H + 1);

   typedef logic [ADDR_W-1:0] buf_addr_t;
   typedef logic [ROW_W-1:0]  row_cnt_t;

   // ch changes fastest, orow slowest
   typedef struct packed {
      logic [OROW_W-1:0] orow;
      logic [OCOL_W-1:0] ocol;
      logic [K_W-1:0]    kh;
      logic [K_W-1:0]    kw;
      logic [CH_W-1:0]   ch;
   } win_pos_t;

endpackage

//--- rtl/stream_fifo.sv
`timescale 1ns/10ps

module stream_fifo #(
   parameter type payload_t = logic [7:0]
) (
   input  logic     clk,
   input  logic     resetn,
   input  logic     push_valid_i,
   output logic     push_ready_o,
   input  payload_t push_data_i,
   output logic     pop_valid_o,
   input  logic     pop_ready_i,
   output payload_t pop_data_o
);

   payload_t   slots [2];
   logic       wr_ptr;
   logic       rd_ptr;
   logic [1:0] count;
   logic       push;
   logic       pop;

   assign push_ready_o = (count != 2'd2);
   assign pop_valid_o  = (count != 2'd0);
   assign pop_data_o   = slots[rd_ptr];

   assign push = push_valid_i && push_ready_o;
   assign pop  = pop_valid_o && pop_ready_i;

   ////////////////////////////////////////////////////////////
   // pointers and fill level
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!resetn) begin
         wr_ptr <= 1'b0;
         rd_ptr <= 1'b0;
         count  <= 2'd0;
      end else begin
         wr_ptr <= wr_ptr ^ push;
         rd_ptr <= rd_ptr ^ pop;
         count  <= count + {1'b0, push} - {1'b0, pop};
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         slots[wr_ptr] <= push_data_i;
      end
   end

   ////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////

   // a push offered to a full fifo must wait, unchanged
   a_push_held: assert property (@(posedge clk) disable iff (!resetn)
      push_valid_i && !push_ready_o |=> push_valid_i && $stable(push_data_i))
      else $error("push offered while full was dropped or changed");

   // head word held while the consumer stalls
   a_pop_stable: assert property (@(posedge clk) disable iff (!resetn)
      pop_valid_o && !pop_ready_i |=> pop_valid_o && $stable(pop_data_o))
      else $error("output changed under back-pressure");

endmodule

//--- rtl/line_buffer.sv
`timescale 1ns/10ps
`include "swu_defs.svh"

module line_buffer (
   input  logic                  clk,
   input  logic                  resetn,
   input  logic                  wr_valid_i,
   output logic                  wr_ready_o,
   input  stream_pkg::pixel_t    wr_pixel_i,
   input  window_pkg::row_cnt_t  release_row_i,
   input  logic                  frame_done_i,
   output window_pkg::row_cnt_t  rows_done_o,
   input  logic                  rd_en_i,
   input  window_pkg::buf_addr_t rd_addr_i,
   output stream_pkg::pixel_t    rd_data_o
);

   localparam int DEPTH = `SWU_BUF_DEPTH;
   localparam int COL_W = (`SWU_IFM_W > 1) ? $clog2(`SWU_IFM_W) : 1;
   localparam int CH_W  = window_pkg::CH_W;

   localparam window_pkg::buf_addr_t LAST_ADDR = window_pkg::buf_addr_t'(DEPTH - 1);
   localparam logic [COL_W-1:0] LAST_COL = COL_W'(`SWU_IFM_W - 1);
   localparam logic [CH_W-1:0]  LAST_CH  = CH_W'(`SWU_CH - 1);

   stream_pkg::pixel_t    mem [DEPTH];
   window_pkg::buf_addr_t wr_addr;
   logic [COL_W-1:0]      wr_col;
   logic [CH_W-1:0]       wr_ch;
   window_pkg::row_cnt_t  wr_row;
   logic                  frame_full;
   logic                  row_free;
   logic                  wr_hs;

   ////////////////////////////////////////////////////////////
   // write side flow control
   ////////////////////////////////////////////////////////////

   // all rows of this frame stored, hold off until turnover
   assign frame_full = (int'(wr_row) >= `SWU_IFM_H);

   // row may only land in a slot no pending window still reads
   assign row_free = (int'(wr_row) < int'(release_row_i) + `SWU_BUF_ROWS);

   assign wr_ready_o  = !frame_full && row_free;
   assign wr_hs       = wr_valid_i && wr_ready_o;
   assign rows_done_o = wr_row;

   ////////////////////////////////////////////////////////////
   // writer position
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!resetn || frame_done_i) begin
         wr_addr <= '0;
         wr_col  <= '0;
         wr_ch   <= '0;
         wr_row  <= '0;
      end else if (wr_hs) begin
         if (wr_addr == LAST_ADDR) begin
            wr_addr <= '0;
         end else begin
            wr_addr <= wr_addr + 1'b1;
         end
         if (wr_ch == LAST_CH) begin
            wr_ch <= '0;
            if (wr_col == LAST_COL) begin
               wr_col <= '0;
               wr_row <= wr_row + 1'b1;
            end else begin
               wr_col <= wr_col + 1'b1;
            end
         end else begin
            wr_ch <= wr_ch + 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // row storage
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (wr_hs) begin
         mem[wr_addr] <= wr_pixel_i;
      end
   end

   // one cycle read latency
   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         rd_data_o <= mem[rd_addr_i];
      end
   end

   ////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////

   a_rows_bound: assert property (@(posedge clk) disable iff (!resetn)
      int'(rows_done_o) <= `SWU_IFM_H)
      else $error("row count ran past the frame height");

   // turnover only once the sequencer has seen every row
   a_turnover_full: assert property (@(posedge clk) disable iff (!resetn)
      frame_done_i |-> int'(rows_done_o) == `SWU_IFM_H)
      else $error("frame turnover before all rows were written");

endmodule

//--- rtl/window_sequencer.sv
`timescale 1ns/10ps
`include "swu_defs.svh"

module window_sequencer (
   input  logic                  clk,
   input  logic                  resetn,
   input  window_pkg::row_cnt_t  rows_done_i,
   input  logic                  out_hs_i,
   output window_pkg::row_cnt_t  release_row_o,
   output logic                  rd_en_o,
   output window_pkg::buf_addr_t rd_addr_o,
   output logic                  tag_valid_o,
   output logic                  tag_win_last_o,
   output logic                  tag_frame_last_o,
   output logic                  frame_done_o
);

   localparam int K        = `SWU_KERNEL;
   localparam int S        = `SWU_STRIDE;
   localparam int CH       = `SWU_CH;
   localparam int ROW_WDS  = `SWU_IFM_W * `SWU_CH;
   localparam int OFM_W    = `SWU_OFM_W;
   localparam int OFM_H    = `SWU_OFM_H;
   localparam int BUF_ROWS = `SWU_BUF_ROWS;

   // matches the output fifo depth
   localparam logic [1:0] CREDITS = 2'd2;

   // last window must end on the last row and column
   if ((((`SWU_IFM_H - K) % S) != 0) || (((`SWU_IFM_W - K) % S) != 0)) begin : g_geom_check
      $error("(IFM - KERNEL) must be a multiple of STRIDE in both directions");
   end

   window_pkg::win_pos_t pos;
   logic [1:0]           credits;
   logic                 rows_ok;
   logic                 issue;
   logic                 win_last;
   logic                 frame_last;
   int                   need_rows;
   int                   in_row;
   int                   in_col;
   int                   slot;

   ////////////////////////////////////////////////////////////
   // read address and issue
   ////////////////////////////////////////////////////////////

   always_comb begin
      need_rows = int'(pos.orow) * S + K;
      in_row    = int'(pos.orow) * S + int'(pos.kh);
      in_col    = int'(pos.ocol) * S + int'(pos.kw);
      slot      = in_row % BUF_ROWS;
   end

   assign rd_addr_o = window_pkg::buf_addr_t'(slot * ROW_WDS + in_col * CH + int'(pos.ch));
   assign release_row_o = window_pkg::row_cnt_t'(int'(pos.orow) * S);

   // every row of this window row already stored
   assign rows_ok = (int'(rows_done_i) >= need_rows);
   assign issue   = rows_ok && (credits != 2'd0);
   assign rd_en_o = issue;

   assign win_last = (int'(pos.kh) == K - 1) && (int'(pos.kw) == K - 1) &&
                     (int'(pos.ch) == CH - 1);
   assign frame_last = win_last && (int'(pos.ocol) == OFM_W - 1) &&
                       (int'(pos.orow) == OFM_H - 1);
   assign frame_done_o = issue && frame_last;

   ////////////////////////////////////////////////////////////
   // window position
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!resetn || frame_done_o) begin
         pos <= '0;
      end else if (issue) begin
         if (int'(pos.ch) != CH - 1) begin
            pos.ch <= pos.ch + 1'b1;
         end else begin
            pos.ch <= '0;
            if (int'(pos.kw) != K - 1) begin
               pos.kw <= pos.kw + 1'b1;
            end else begin
               pos.kw <= '0;
               if (int'(pos.kh) != K - 1) begin
                  pos.kh <= pos.kh + 1'b1;
               end else begin
                  pos.kh <= '0;
                  if (int'(pos.ocol) != OFM_W - 1) begin
                     pos.ocol <= pos.ocol + 1'b1;
                  end else begin
                     pos.ocol <= '0;
                     pos.orow <= pos.orow + 1'b1;
                  end
               end
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // output credits and tags
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!resetn) begin
         credits <= CREDITS;
      end else begin
         credits <= credits + {1'b0, out_hs_i} - {1'b0, issue};
      end
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         tag_valid_o <= 1'b0;
      end else begin
         tag_valid_o <= issue;
      end
   end

   // lines up with rd_data
   always_ff @(posedge clk) begin
      tag_win_last_o   <= win_last;
      tag_frame_last_o <= frame_last;
   end

   // no handshake can return a credit that was never taken
   a_credit_bound: assert property (@(posedge clk) disable iff (!resetn)
      credits <= CREDITS && !(out_hs_i && credits == CREDITS))
      else $error("output credits out of range");

endmodule

//--- rtl/sliding_window_unit.sv
`timescale 1ns/10ps

module sliding_window_unit (
   input  logic                  clk,
   input  logic                  resetn,
   input  logic                  in_valid_i,
   output logic                  in_ready_o,
   input  stream_pkg::pixel_t    in_pixel_i,
   output logic                  out_valid_o,
   input  logic                  out_ready_i,
   output stream_pkg::out_beat_t out_beat_o
);

   logic                  wr_valid;
   logic                  wr_ready;
   stream_pkg::pixel_t    wr_pixel;
   window_pkg::row_cnt_t  rows_done;
   window_pkg::row_cnt_t  release_row;
   logic                  frame_done;
   logic                  rd_en;
   window_pkg::buf_addr_t rd_addr;
   stream_pkg::pixel_t    rd_data;
   logic                  tag_valid;
   logic                  tag_win_last;
   logic                  tag_frame_last;
   logic                  out_hs;
   stream_pkg::out_beat_t push_beat;

   assign out_hs = out_valid_o && out_ready_i;

   // read data meets its delayed tags here
   assign push_beat = '{data: rd_data, win_last: tag_win_last, frame_last: tag_frame_last};

   stream_fifo #(.payload_t(stream_pkg::pixel_t)) in_fifo (
      .clk(clk), .resetn(resetn),
      .push_valid_i(in_valid_i), .push_ready_o(in_ready_o), .push_data_i(in_pixel_i),
      .pop_valid_o(wr_valid), .pop_ready_i(wr_ready), .pop_data_o(wr_pixel)
   );

   line_buffer line_buffer_inst (
      .clk(clk), .resetn(resetn),
      .wr_valid_i(wr_valid), .wr_ready_o(wr_ready), .wr_pixel_i(wr_pixel),
      .release_row_i(release_row), .frame_done_i(frame_done), .rows_done_o(rows_done),
      .rd_en_i(rd_en), .rd_addr_i(rd_addr), .rd_data_o(rd_data)
   );

   window_sequencer window_sequencer_inst (
      .clk(clk), .resetn(resetn),
      .rows_done_i(rows_done), .out_hs_i(out_hs), .release_row_o(release_row),
      .rd_en_o(rd_en), .rd_addr_o(rd_addr),
      .tag_valid_o(tag_valid), .tag_win_last_o(tag_win_last),
      .tag_frame_last_o(tag_frame_last), .frame_done_o(frame_done)
   );

   // credits keep this fifo from ever being pushed while full
   stream_fifo #(.payload_t(stream_pkg::out_beat_t)) out_fifo (
      .clk(clk), .resetn(resetn),
      .push_valid_i(tag_valid), .push_ready_o(), .push_data_i(push_beat),
      .pop_valid_o(out_valid_o), .pop_ready_i(out_ready_i), .pop_data_o(out_beat_o)
   );

endmodule

//--- test/tb_sliding_window_unit.sv
`timescale 1ns/10ps
`include "swu_defs.svh"

module tb_sliding_window_unit;

   localparam int H           = `SWU_IFM_H;
   localparam int W           = `SWU_IFM_W;
   localparam int CH          = `SWU_CH;
   localparam int K           = `SWU_KERNEL;
   localparam int S           = `SWU_STRIDE;
   localparam int OFM_W       = `SWU_OFM_W;
   localparam int OFM_H       = `SWU_OFM_H;
   localparam int WIN_WORDS   = K * K * CH;
   localparam int FRAME_WORDS = OFM_W * OFM_H * WIN_WORDS;
   localparam int FRAMES      = 2;
   localparam int TOTAL_IN    = FRAMES * H * W * CH;
   localparam int TOTAL_OUT   = FRAMES * FRAME_WORDS;
   localparam int RUN_LIMIT   = 20000;
   localparam int READY_LIMIT = 100;

   logic                  clk;
   logic                  resetn;
   logic                  in_valid;
   logic                  in_ready;
   stream_pkg::pixel_t    in_pixel;
   logic                  out_valid;
   logic                  out_ready;
   stream_pkg::out_beat_t out_beat;
   logic                  out_hs;

   stream_pkg::pixel_t pix_mem [TOTAL_IN];
   stream_pkg::pixel_t exp_data [TOTAL_OUT];
   logic [15:0]        lfsr;
   int                 in_idx;
   int                 out_idx;
   int                 data_errors;
   int                 tag_errors;
   int                 flow_errors;
   int                 timeout_errors;

   sliding_window_unit sliding_window_unit_inst (
      .clk(clk), .resetn(resetn),
      .in_valid_i(in_valid), .in_ready_o(in_ready), .in_pixel_i(in_pixel),
      .out_valid_o(out_valid), .out_ready_i(out_ready), .out_beat_o(out_beat)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   assign out_hs = out_valid && out_ready;

   ////////////////////////////////////////////////////////////
   // stimulus source and reference model
   ////////////////////////////////////////////////////////////

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic random_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v = {v[30:0], lfsr[0]};
      end
   endtask

   // window order is orow, ocol, kh, kw, ch with ch fastest
   task automatic build_model();
      logic [31:0] r;
      int          src;
      int          n;
      for (int i = 0; i < TOTAL_IN; i++) begin
         random_bits(stream_pkg::PIXEL_W, r);
         pix_mem[i] = stream_pkg::pixel_t'(r);
      end
      n = 0;
      for (int f = 0; f < FRAMES; f++) begin
         for (int orow = 0; orow < OFM_H; orow++) begin
            for (int ocol = 0; ocol < OFM_W; ocol++) begin
               for (int kh = 0; kh < K; kh++) begin
                  for (int kw = 0; kw < K; kw++) begin
                     for (int ch = 0; ch < CH; ch++) begin
                        src = ((f * H + orow * S + kh) * W + ocol * S + kw) * CH + ch;
                        exp_data[n] = pix_mem[src];
                        n++;
                     end
                  end
               end
            end
         end
      end
   endtask

   always_ff @(posedge clk) begin
      if (!resetn) begin
         in_idx  <= 0;
         out_idx <= 0;
      end else begin
         if (in_valid && in_ready) begin
            in_idx <= in_idx + 1;
         end
         if (out_hs) begin
            out_idx <= out_idx + 1;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////

   a_reset_state: assert property (@(posedge clk) $rose(resetn) |-> !out_valid && in_ready)
      else begin
         flow_errors++;
         $display("FAILED %0t: after reset out_valid=%b in_ready=%b",
                  $time, $sampled(out_valid), $sampled(in_ready));
      end

   a_beat_data: assert property (@(posedge clk) disable iff (!resetn)
      out_hs && (out_idx < TOTAL_OUT) |-> out_beat.data == exp_data[out_idx])
      else begin
         data_errors++;
         $display("FAILED %0t: word %0d data %h, expected %h", $time, $sampled(out_idx),
                  $sampled(out_beat.data), exp_data[$sampled(out_idx)]);
      end

   a_win_last: assert property (@(posedge clk) disable iff (!resetn)
      out_hs |-> out_beat.win_last == ((out_idx % WIN_WORDS) == WIN_WORDS - 1))
      else begin
         tag_errors++;
         $display("FAILED %0t: word %0d win_last=%b", $time, $sampled(out_idx),
                  $sampled(out_beat.win_last));
      end

   a_frame_last: assert property (@(posedge clk) disable iff (!resetn)
      out_hs |-> out_beat.frame_last == ((out_idx % FRAME_WORDS) == FRAME_WORDS - 1))
      else begin
         tag_errors++;
         $display("FAILED %0t: word %0d frame_last=%b", $time, $sampled(out_idx),
                  $sampled(out_beat.frame_last));
      end

   a_no_extra: assert property (@(posedge clk) disable iff (!resetn)
      out_hs |-> out_idx < TOTAL_OUT)
      else begin
         flow_errors++;
         $display("FAILED %0t: output word beyond the %0d expected", $time, TOTAL_OUT);
      end

   // stalled output word must not move
   a_out_held: assert property (@(posedge clk) disable iff (!resetn)
      out_valid && !out_ready |=> out_valid && $stable(out_beat))
      else begin
         flow_errors++;
         $display("FAILED %0t: output word changed or dropped while stalled", $time);
      end

   ////////////////////////////////////////////////////////////
   // run
   ////////////////////////////////////////////////////////////

   initial begin
      int          waited;
      int          offer_idx;
      logic [31:0] r;
      resetn         = 1'b0;
      in_valid       = 1'b0;
      in_pixel       = '0;
      out_ready      = 1'b0;
      lfsr           = 16'd61;
      data_errors    = 0;
      tag_errors     = 0;
      flow_errors    = 0;
      timeout_errors = 0;
      build_model();
      repeat (10) @(posedge clk);
      @(negedge clk);
      resetn = 1'b1;

      waited = 0;
      while (!in_ready && waited < READY_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (!in_ready) begin
         timeout_errors++;
         $display("timeout: input never became ready after reset");
      end

      // both ports decided once per falling edge
      waited    = 0;
      offer_idx = 0;
      while (timeout_errors == 0 && out_idx < TOTAL_OUT) begin
         @(negedge clk);
         waited++;
         if (waited > RUN_LIMIT) begin
            timeout_errors++;
            $display("timeout: waiting for output word %0d of %0d, %0d input words taken",
                     out_idx, TOTAL_OUT, in_idx);
         end
         if (in_valid && in_idx != offer_idx) begin
            in_valid = 1'b0;
         end
         if (!in_valid && in_idx < TOTAL_IN) begin
            random_bits(1, r);
            // one bit set means an idle cycle
            if (!r[0]) begin
               offer_idx = in_idx;
               in_pixel  = pix_mem[in_idx];
               in_valid  = 1'b1;
            end
         end
         random_bits(2, r);
         out_ready = (r[1:0] != 2'b00);
      end

      // any word in the quiet period trips a_no_extra
      in_valid  = 1'b0;
      out_ready = 1'b1;
      waited    = 0;
      while (waited < 20) begin
         @(negedge clk);
         waited++;
      end

      $display("errors: data %0d, tags %0d, flow %0d, timeouts %0d",
               data_errors, tag_errors, flow_errors, timeout_errors);
      if (data_errors + tag_errors + flow_errors + timeout_errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

//--- list.f
+incdir+rtl
rtl/stream_pkg.sv
rtl/window_pkg.sv
rtl/stream_fifo.sv
rtl/line_buffer.sv
rtl/window_sequencer.sv
rtl/sliding_window_unit.sv
test/tb_sliding_window_unit.sv
